//--- hw/ms6205Pkg.sv
package ms6205Pkg;

    typedef enum logic [2:0] {
        VIEW_RESTART = 3'b000,
        VIEW_IRAM    = 3'b010,
        VIEW_DRAM    = 3'b011,
        VIEW_CIO     = 3'b101
    } viewT;

    typedef logic [7:0]  charT;
    typedef logic [3:0]  opcodeT;
    typedef logic [11:0] dataWordT;
    typedef logic [15:0] bcdAddrT;

    localparam int POS_WIDTH       = 8;
    localparam int DATA_WORDS      = 10;
    localparam int DATA_ADDR_WIDTH = $clog2(DATA_WORDS);
    localparam int KEY_COUNT       = 40;
    localparam int HEADER_COLS     = 6;

    // Front panel key positions.
    localparam int KEY_IRAM     = 0;
    localparam int KEY_DRAM     = 1;
    localparam int KEY_CIO      = 2;
    localparam int KEY_HARD_RST = 3;

    // Mnemonic letters follow the ten digit opcodes.
    localparam charT OPCODE_TABLE [16] = '{
        "0", "1", "2", "3", "4", "5", "6", "7",
        "8", "9", "A", "S", "J", "C", "R", "H"
    };

    function automatic charT opcodeSymbol(input opcodeT op);
        return OPCODE_TABLE[op];
    endfunction

endpackage

//--- hw/memWriteIf.sv
`timescale 1ns/1ps

interface memWriteIf;

    logic                                      insnWrite;
    logic [ms6205Pkg::POS_WIDTH-1:0]           insnAddr;
    ms6205Pkg::opcodeT                         insnData;
    logic                                      dataWrite;
    logic [ms6205Pkg::DATA_ADDR_WIDTH-1:0]     dataAddr;
    ms6205Pkg::dataWordT                       dataValue;

    modport host (
        output insnWrite, insnAddr, insnData,
        output dataWrite, dataAddr, dataValue
    );

    modport ram (
        input insnWrite, insnAddr, insnData,
        input dataWrite, dataAddr, dataValue
    );

endinterface

//--- hw/displayRam.sv
`timescale 1ns/1ps

module displayRam #(
    parameter type entryT = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic                       Clk,
    input  logic                       rstN,
    input  logic                       writeEn,
    input  logic [$clog2(DEPTH)-1:0]   writeAddr,
    input  entryT                      writeData,
    input  logic [$clog2(DEPTH)-1:0]   readAddr,
    output entryT                      readData
);

    entryT mem [DEPTH];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
    end

    // Out of range reads return zero.
    assign readData = (readAddr < DEPTH) ? mem[readAddr] : '0;

endmodule

//--- hw/viewSelector.sv
`timescale 1ns/1ps

module viewSelector (
    input  logic                               Clk,
    input  logic                               rstN,
    input  logic                               tick1ms,
    input  logic [ms6205Pkg::KEY_COUNT-1:0]    keys,
    input  logic                               cioAck,
    output ms6205Pkg::viewT                    view
);

    ms6205Pkg::viewT nextView;

    // Restart always falls through to the instruction view.
    always_comb begin
        if (view == ms6205Pkg::VIEW_RESTART) begin
            nextView = ms6205Pkg::VIEW_IRAM;
        end else if (keys[ms6205Pkg::KEY_IRAM]) begin
            nextView = ms6205Pkg::VIEW_IRAM;
        end else if (keys[ms6205Pkg::KEY_DRAM]) begin
            nextView = ms6205Pkg::VIEW_DRAM;
        end else if (keys[ms6205Pkg::KEY_CIO] || cioAck) begin
            nextView = ms6205Pkg::VIEW_CIO;
        end else if (keys[ms6205Pkg::KEY_HARD_RST]) begin
            nextView = ms6205Pkg::VIEW_RESTART;
        end else begin
            nextView = view;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            view <= ms6205Pkg::VIEW_RESTART;
        end else if (tick1ms) begin
            view <= nextView;
        end
    end

endmodule

//--- hw/refreshScanner.sv
`timescale 1ns/1ps

module refreshScanner #(
    parameter int COLUMNS = 16,
    parameter int ROWS    = 10
) (
    input  logic                               Clk,
    input  logic                               rstN,
    input  logic                               tick1ms,
    output logic [ms6205Pkg::POS_WIDTH-1:0]    pos
);

    localparam logic [ms6205Pkg::POS_WIDTH-1:0] LAST_POS =
        ms6205Pkg::POS_WIDTH'(ROWS * COLUMNS - 1);

    // One screen position per refresh tick.
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pos <= '0;
        end else if (tick1ms) begin
            if (pos == LAST_POS) begin
                pos <= '0;
            end else begin
                pos <= pos + 1'b1;
            end
        end
    end

endmodule

//--- hw/consoleBuffer.sv
`timescale 1ns/1ps

module consoleBuffer #(
    parameter int COLUMNS = 16,
    parameter int ROWS    = 10
) (
    input  logic                               Clk,
    input  logic                               rstN,
    input  logic                               cout,
    input  ms6205Pkg::charT                    symbol,
    input  ms6205Pkg::viewT                    view,
    input  logic [ms6205Pkg::POS_WIDTH-1:0]    pos,
    output logic                               cioAck,
    output ms6205Pkg::charT                    consoleChar
);

    localparam int SCREEN_SIZE = ROWS * COLUMNS;
    localparam int SCREEN_AW   = $clog2(SCREEN_SIZE);
    localparam logic [ms6205Pkg::POS_WIDTH-1:0] LAST_POS =
        ms6205Pkg::POS_WIDTH'(SCREEN_SIZE - 1);

    logic [ms6205Pkg::POS_WIDTH-1:0] writePtr;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            writePtr <= '0;
            cioAck   <= 1'b0;
        end else if (cout) begin
            writePtr <= (writePtr == LAST_POS) ? '0 : writePtr + 1'b1;
            cioAck   <= 1'b1;
        end else if (view == ms6205Pkg::VIEW_CIO) begin
            // Attention is served once the console is on screen.
            cioAck <= 1'b0;
        end
    end

    displayRam #(
        .entryT (ms6205Pkg::charT),
        .DEPTH  (SCREEN_SIZE)
    ) consoleStore (
        .Clk       (Clk),
        .rstN      (rstN),
        .writeEn   (cout),
        .writeAddr (writePtr[SCREEN_AW-1:0]),
        .writeData (symbol),
        .readAddr  (pos[SCREEN_AW-1:0]),
        .readData  (consoleChar)
    );

endmodule

//--- hw/screenFormatter.sv
`timescale 1ns/1ps

module screenFormatter #(
    parameter int COLUMNS = 16,
    parameter int ROWS    = 10
) (
    input  logic                               Clk,
    input  logic                               rstN,
    input  logic                               tick1ms,
    input  logic [ms6205Pkg::POS_WIDTH-1:0]    pos,
    input  ms6205Pkg::viewT                    view,
    input  ms6205Pkg::bcdAddrT                 ipAddress,
    input  ms6205Pkg::bcdAddrT                 apAddress,
    input  ms6205Pkg::charT                    consoleChar,
    memWriteIf.ram                             mem,
    output logic                               charValid,
    output logic [ms6205Pkg::POS_WIDTH-1:0]    address,
    output ms6205Pkg::charT                    dataN
);

    localparam int SCREEN_SIZE = ROWS * COLUMNS;
    localparam int SCREEN_AW   = $clog2(SCREEN_SIZE);
    localparam logic [ms6205Pkg::POS_WIDTH-1:0] COLS_W = ms6205Pkg::POS_WIDTH'(COLUMNS);

    logic [ms6205Pkg::POS_WIDTH-1:0]  row;
    logic [ms6205Pkg::POS_WIDTH-1:0]  col;
    logic [ms6205Pkg::POS_WIDTH-1:0]  dataRow;
    ms6205Pkg::opcodeT                insnOp;
    ms6205Pkg::dataWordT              dataWord;
    ms6205Pkg::charT                  nextChar;
    ms6205Pkg::charT                  charQ;

    function automatic ms6205Pkg::charT digitChar(input logic [3:0] digit);
        return 8'h30 + {4'h0, digit};
    endfunction

    // Digit 0 is the most significant.
    function automatic ms6205Pkg::charT pointerChar(input ms6205Pkg::bcdAddrT ptr,
                                                    input logic [1:0] idx);
        return digitChar(ptr[4 * (3 - idx) +: 4]);
    endfunction

    assign row = pos / COLS_W;
    assign col = pos % COLS_W;

    // Right half of a data row shows the next word.
    assign dataRow = (col >= 12) ? row + 1'b1 : row;

    displayRam #(
        .entryT (ms6205Pkg::opcodeT),
        .DEPTH  (SCREEN_SIZE)
    ) insnMirror (
        .Clk       (Clk),
        .rstN      (rstN),
        .writeEn   (mem.insnWrite),
        .writeAddr (mem.insnAddr[SCREEN_AW-1:0]),
        .writeData (mem.insnData),
        .readAddr  (pos[SCREEN_AW-1:0]),
        .readData  (insnOp)
    );

    displayRam #(
        .entryT (ms6205Pkg::dataWordT),
        .DEPTH  (ms6205Pkg::DATA_WORDS)
    ) dataMirror (
        .Clk       (Clk),
        .rstN      (rstN),
        .writeEn   (mem.dataWrite),
        .writeAddr (mem.dataAddr),
        .writeData (mem.dataValue),
        .readAddr  (dataRow[ms6205Pkg::DATA_ADDR_WIDTH-1:0]),
        .readData  (dataWord)
    );

    always_comb begin
        nextChar = " ";
        case (view)
            ms6205Pkg::VIEW_IRAM: begin
                if (col < ms6205Pkg::HEADER_COLS - 2) begin
                    nextChar = pointerChar(ipAddress, col[1:0]);
                end else if (col == ms6205Pkg::HEADER_COLS - 2) begin
                    nextChar = "0";
                end else if (col == ms6205Pkg::HEADER_COLS - 1) begin
                    nextChar = ":";
                end else begin
                    nextChar = ms6205Pkg::opcodeSymbol(insnOp);
                end
            end
            ms6205Pkg::VIEW_DRAM: begin
                // Lower half of the panel stays blank.
                if (row < ROWS / 2) begin
                    case (col)
                        0, 1, 2, 3: nextChar = pointerChar(apAddress, col[1:0]);
                        4:          nextChar = digitChar(row[3:0]);
                        5:          nextChar = ":";
                        7, 12:      nextChar = digitChar(dataWord[11:8]);
                        8, 13:      nextChar = digitChar(dataWord[7:4]);
                        9, 14:      nextChar = digitChar(dataWord[3:0]);
                        default:    nextChar = " ";
                    endcase
                end
            end
            default: begin
                nextChar = consoleChar;
            end
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            charValid <= 1'b0;
        end else begin
            charValid <= tick1ms;
        end
    end

    always_ff @(posedge Clk) begin
        if (tick1ms) begin
            address <= pos;
            charQ   <= nextChar;
        end
    end

    // Panel data lines are active low.
    assign dataN = ~charQ;

endmodule

//--- hw/ms6205Display.sv
`timescale 1ns/1ps

module ms6205Display #(
    parameter int COLUMNS = 16,
    parameter int ROWS    = 10
) (
    input  logic                                       Clk,
    input  logic                                       rstN,
    input  logic                                       tick1ms,
    input  logic [ms6205Pkg::KEY_COUNT-1:0]            keys,
    input  logic                                       cout,
    input  ms6205Pkg::charT                            symbol,
    input  logic                                       insnWrite,
    input  logic [ms6205Pkg::POS_WIDTH-1:0]            insnAddr,
    input  ms6205Pkg::opcodeT                          insnData,
    input  logic                                       dataWrite,
    input  logic [ms6205Pkg::DATA_ADDR_WIDTH-1:0]      dataAddr,
    input  ms6205Pkg::dataWordT                        dataValue,
    input  ms6205Pkg::bcdAddrT                         ipAddress,
    input  ms6205Pkg::bcdAddrT                         apAddress,
    input  logic [2:0]                                 dpcState,
    output logic                                       charValid,
    output logic [ms6205Pkg::POS_WIDTH-1:0]            address,
    output ms6205Pkg::charT                            dataN,
    output logic                                       marker,
    output logic                                       cioAck
);

    ms6205Pkg::viewT                   view;
    logic [ms6205Pkg::POS_WIDTH-1:0]   pos;
    ms6205Pkg::charT                   consoleChar;

    memWriteIf memBus ();

    assign memBus.insnWrite = insnWrite;
    assign memBus.insnAddr  = insnAddr;
    assign memBus.insnData  = insnData;
    assign memBus.dataWrite = dataWrite;
    assign memBus.dataAddr  = dataAddr;
    assign memBus.dataValue = dataValue;

    // Highlights the current instruction during fetch.
    assign marker = (view == ms6205Pkg::VIEW_IRAM) && (dpcState == 3'd2);

    viewSelector viewSel (
        .Clk     (Clk),
        .rstN    (rstN),
        .tick1ms (tick1ms),
        .keys    (keys),
        .cioAck  (cioAck),
        .view    (view)
    );

    refreshScanner #(.COLUMNS(COLUMNS), .ROWS(ROWS)) scanner (
        .Clk     (Clk),
        .rstN    (rstN),
        .tick1ms (tick1ms),
        .pos     (pos)
    );

    consoleBuffer #(.COLUMNS(COLUMNS), .ROWS(ROWS)) console (
        .Clk         (Clk),
        .rstN        (rstN),
        .cout        (cout),
        .symbol      (symbol),
        .view        (view),
        .pos         (pos),
        .cioAck      (cioAck),
        .consoleChar (consoleChar)
    );

    screenFormatter #(.COLUMNS(COLUMNS), .ROWS(ROWS)) formatter (
        .Clk         (Clk),
        .rstN        (rstN),
        .tick1ms     (tick1ms),
        .pos         (pos),
        .view        (view),
        .ipAddress   (ipAddress),
        .apAddress   (apAddress),
        .consoleChar (consoleChar),
        .mem         (memBus.ram),
        .charValid   (charValid),
        .address     (address),
        .dataN       (dataN)
    );

endmodule

//--- verification/ms6205_assertions.sv
`timescale 1ns/1ps

module ms6205Assertions (
    input logic        Clk,
    input logic        rstN,
    input logic        tick1ms,
    input logic        charValid,
    input logic [7:0]  address,
    input logic        cioAck,
    input logic        marker,
    input logic [2:0]  dpcState
);

    int failCount = 0;

    // One character per tick, one cycle later.
    charFollowsTick: assert property (@(posedge Clk) disable iff (!rstN)
        charValid == $past(tick1ms))
        else begin
            failCount++;
            $error("charValid does not follow tick1ms by one cycle");
        end

    addressOnScreen: assert property (@(posedge Clk) disable iff (!rstN)
        charValid |-> address < 8'd160)
        else begin
            failCount++;
            $error("address beyond the last screen position");
        end

    quietInReset: assert property (@(posedge Clk)
        !rstN |-> !charValid && !cioAck)
        else begin
            failCount++;
            $error("charValid or cioAck high during reset");
        end

    markerNeedsFetch: assert property (@(posedge Clk)
        marker |-> dpcState == 3'd2)
        else begin
            failCount++;
            $error("marker high outside dpcState 2");
        end

endmodule

bind ms6205Display ms6205Assertions outputChecks (
    .Clk       (Clk),
    .rstN      (rstN),
    .tick1ms   (tick1ms),
    .charValid (charValid),
    .address   (address),
    .cioAck    (cioAck),
    .marker    (marker),
    .dpcState  (dpcState)
);

//--- verification/ms6205Tb.sv
`timescale 1ns/1ps

module ms6205Tb;

    localparam int TRACE_DEPTH = 64;
    localparam int WAIT_LIMIT  = 20;

    logic                                   Clk = 1'b0;
    logic                                   rstN;
    logic                                   tick1ms;
    logic [ms6205Pkg::KEY_COUNT-1:0]        keys;
    logic                                   cout;
    ms6205Pkg::charT                        symbol;
    logic                                   insnWrite;
    logic [ms6205Pkg::POS_WIDTH-1:0]        insnAddr;
    ms6205Pkg::opcodeT                      insnData;
    logic                                   dataWrite;
    logic [ms6205Pkg::DATA_ADDR_WIDTH-1:0]  dataAddr;
    ms6205Pkg::dataWordT                    dataValue;
    ms6205Pkg::bcdAddrT                     ipAddress;
    ms6205Pkg::bcdAddrT                     apAddress;
    logic [2:0]                             dpcState;
    logic                                   charValid;
    logic [ms6205Pkg::POS_WIDTH-1:0]        address;
    ms6205Pkg::charT                        dataN;
    logic                                   marker;
    logic                                   cioAck;

    // Command in the top nibble, arguments below.
    logic [47:0] trace [TRACE_DEPTH];

    ms6205Display i_dut (.*);

    initial begin
        forever #50 Clk = ~Clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            abortRun("value mismatch");
        end
    endtask

    // Only the last character of a run is compared.
    task automatic tickAndCheck(input int count, input logic [7:0] expAddr,
                                input logic [7:0] expChar);
        int         waited;
        logic [7:0] expData;
        expData = ~expChar;
        for (int i = 0; i < count; i++) begin
            @(negedge Clk);
            tick1ms = 1'b1;
            @(negedge Clk);
            tick1ms = 1'b0;
            waited = 0;
            while (!charValid) begin
                if (waited == WAIT_LIMIT) begin
                    abortRun("no character appeared after a refresh tick");
                end
                @(negedge Clk);
                waited++;
            end
        end
        checkValue("address", expAddr, address);
        checkValue("dataN", expData, dataN);
    endtask

    task automatic writeInsn(input logic [7:0] addr, input ms6205Pkg::opcodeT op);
        @(negedge Clk);
        insnWrite = 1'b1;
        insnAddr  = addr;
        insnData  = op;
        @(negedge Clk);
        insnWrite = 1'b0;
    endtask

    task automatic writeWord(input logic [3:0] addr, input ms6205Pkg::dataWordT value);
        @(negedge Clk);
        dataWrite = 1'b1;
        dataAddr  = addr;
        dataValue = value;
        @(negedge Clk);
        dataWrite = 1'b0;
    endtask

    task automatic printSymbol(input ms6205Pkg::charT sym);
        @(negedge Clk);
        cout   = 1'b1;
        symbol = sym;
        @(negedge Clk);
        cout = 1'b0;
    endtask

    task automatic setDpcState(input logic [2:0] state, input logic expMarker);
        @(negedge Clk);
        dpcState = state;
        @(negedge Clk);
        checkValue("marker", expMarker, marker);
    endtask

    initial begin
        logic [47:0] entry;
        bit          done;
        rstN      = 1'b0;
        tick1ms   = 1'b0;
        keys      = '0;
        cout      = 1'b0;
        symbol    = '0;
        insnWrite = 1'b0;
        insnAddr  = '0;
        insnData  = '0;
        dataWrite = 1'b0;
        dataAddr  = '0;
        dataValue = '0;
        ipAddress = '0;
        apAddress = '0;
        dpcState  = '0;
        done      = 1'b0;
        $readmemh("verification/ms6205_trace.txt", trace);
        repeat (5) @(negedge Clk);
        rstN = 1'b1;
        @(negedge Clk);
        checkValue("charValid", 1'b0, charValid);
        checkValue("cioAck", 1'b0, cioAck);
        checkValue("marker", 1'b0, marker);
        for (int idx = 0; idx < TRACE_DEPTH && !done; idx++) begin
            entry = trace[idx];
            case (entry[47:44])
                4'h1: begin
                    @(negedge Clk);
                    keys = entry[39:0];
                end
                4'h2: tickAndCheck(entry[23:16], entry[15:8], entry[7:0]);
                4'h3: writeInsn(entry[15:8], entry[3:0]);
                4'h4: writeWord(entry[19:16], entry[11:0]);
                4'h5: printSymbol(entry[7:0]);
                4'h6: begin
                    @(negedge Clk);
                    ipAddress = entry[31:16];
                    apAddress = entry[15:0];
                end
                4'h7: setDpcState(entry[10:8], entry[0]);
                4'h8: begin
                    @(negedge Clk);
                    checkValue("cioAck", entry[0], cioAck);
                end
                4'hf: done = 1'b1;
                default: abortRun("unknown command in the trace file");
            endcase
        end
        if (!done) begin
            abortRun("trace file ended without an end command");
        end else if (i_dut.outputChecks.failCount != 0) begin
            abortRun("a bound assertion on the outputs failed");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- verification/ms6205_trace.txt
// cmd[47:44] 1 keys[39:0] | 2 ticks[23:16] addr[15:8] char[7:0] | 3 insn addr[15:8] op[3:0]
// 4 data addr[19:16] word[11:0] | 5 symbol[7:0] | 6 ip[31:16] ap[15:0]
// 7 dpcState[10:8] marker[0] | 8 cioAck[0] | f end
600012340567
800000000000
700000000000
30000000060A
300000000705
300000000F0F
// Restart frame, then instruction view
200000010000
700000000201
200000010132
200000030430
20000001053A
200000010641
200000010735
200000080F48
700000000000
// Data view
400000000123
400000010456
400000020789
100000000002
200000011031
100000000000
200000011135
200000031431
20000001153A
200000021734
200000021936
200000011A20
200000021C37
200000021E39
200000011F20
200000315020
200000045420
// Console
500000000051
800000000001
200000015520
800000000000
2000004B0051
200000A00051
// Key priority
100000000003
200000010100
100000000000
700000000201
700000000000
200000010233
100000000008
200000010334
100000000000
200000010400
20000001053A
f00000000000

//--- filelist.f
hw/ms6205Pkg.sv
hw/memWriteIf.sv
hw/displayRam.sv
hw/viewSelector.sv
hw/refreshScanner.sv
hw/consoleBuffer.sv
hw/screenFormatter.sv
hw/ms6205Display.sv
verification/ms6205_assertions.sv
verification/ms6205Tb.sv
